/* hw/dma_defines.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Geometry of the DMA request path and the scratchpad.
// Include wherever the widths or the group count are needed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// Byte address and burst length
`define DMA_ADDR_WIDTH 32
`define DMA_LEN_WIDTH 16

// Interleaving of the scratchpad
`define DMA_NUM_GROUPS 4
`define DMA_BANKS_PER_GROUP 16
`define DMA_BANK_BYTES 4

// Scratchpad region
`define DMA_TCDM_BASE 32'h0000_0000
`define DMA_TCDM_SIZE 4096

`endif

/* hw/dma_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types shared by all stages of the DMA request path and by
// the testbench. Widths follow from dma_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "dma_defines.svh"

package dma_pkg;

  // Bytes owned by one group in a row, and bytes in a full row
  localparam int unsigned GroupBytes = `DMA_BANKS_PER_GROUP * `DMA_BANK_BYTES;
  localparam int unsigned RowBytes = `DMA_NUM_GROUPS * GroupBytes;

  localparam int unsigned OffsetWidth = $clog2(GroupBytes);
  localparam int unsigned GroupIdxWidth = $clog2(`DMA_NUM_GROUPS);
  localparam int unsigned RowWidth = $clog2(`DMA_TCDM_SIZE / RowBytes);
  localparam int unsigned TagWidth = `DMA_ADDR_WIDTH - RowWidth - GroupIdxWidth - OffsetWidth;

  typedef logic [`DMA_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`DMA_LEN_WIDTH-1:0] len_t;

  localparam addr_t TcdmBase = addr_t'(`DMA_TCDM_BASE);

  // Interleaved view of a scratchpad address
  typedef struct packed {
    logic [TagWidth-1:0]      tag;
    logic [RowWidth-1:0]      row;
    logic [GroupIdxWidth-1:0] group;
    logic [OffsetWidth-1:0]   offset;
  } tcdm_field_t;

  typedef union packed {
    addr_t       raw;
    tcdm_field_t fields;
  } tcdm_addr_u;

  typedef struct packed {
    addr_t      src;
    tcdm_addr_u dst;
    len_t       num_bytes;
  } dma_req_t;

endpackage

/* hw/dma_req_spill.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-entry spill register on the incoming DMA request.
// Cuts both the data path and the ready path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module dma_req_spill (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  dma_pkg::dma_req_t data_i,
  input  logic              valid_i,
  output logic              ready_o,
  output dma_pkg::dma_req_t data_o,
  output logic              valid_o,
  input  logic              ready_i
);
  import dma_pkg::*;

  dma_req_t a_data_q;
  dma_req_t b_data_q;
  logic     a_full_q;
  logic     b_full_q;
  logic     a_fill;
  logic     a_drain;
  logic     b_fill;
  logic     b_drain;

  assign a_fill = valid_i && ready_o;
  // A leaves either to the output or into B when the output stalls
  assign a_drain = a_full_q && !b_full_q && ready_i;
  assign b_fill = a_full_q && !b_full_q && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      a_full_q <= a_fill || (a_full_q && !a_drain && !b_fill);
      b_full_q <= b_fill || (b_full_q && !b_drain);
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // B always holds the older entry
  assign data_o = b_full_q ? b_data_q : a_data_q;
  assign valid_o = a_full_q || b_full_q;
  assign ready_o = !(a_full_q && b_full_q);

endmodule

/* hw/dma_row_splitter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cuts a burst into pieces that never cross a scratchpad row.
// Holds one burst at a time and emits one piece per handshake
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module dma_row_splitter (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  dma_pkg::dma_req_t req_i,
  input  logic              valid_i,
  output logic              ready_o,
  output dma_pkg::dma_req_t piece_o,
  output logic              valid_o,
  input  logic              ready_i,
  output logic              busy_o
);
  import dma_pkg::*;

  logic                                 busy_q;
  dma_req_t                             cur_q;
  tcdm_addr_u                           dst_rel;
  logic [GroupIdxWidth+OffsetWidth-1:0] row_off;
  len_t                                 row_room;
  len_t                                 piece_len;
  logic                                 last_piece;
  logic                                 accept;
  logic                                 advance;

  // Byte position of the remaining burst inside its row
  assign dst_rel.raw = cur_q.dst.raw - TcdmBase;
  assign row_off = {dst_rel.fields.group, dst_rel.fields.offset};
  assign row_room = len_t'(RowBytes) - len_t'(row_off);

  assign piece_len = (cur_q.num_bytes < row_room) ? cur_q.num_bytes : row_room;
  assign last_piece = (piece_len == cur_q.num_bytes);

  assign accept = valid_i && ready_o;
  assign advance = valid_o && ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
    end else if (accept) begin
      // Empty bursts are dropped here
      busy_q <= (req_i.num_bytes != '0);
    end else if (advance && last_piece) begin
      busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      cur_q <= req_i;
    end else if (advance) begin
      cur_q.src <= cur_q.src + addr_t'(piece_len);
      cur_q.dst.raw <= cur_q.dst.raw + addr_t'(piece_len);
      cur_q.num_bytes <= cur_q.num_bytes - piece_len;
    end
  end

  assign piece_o.src = cur_q.src;
  assign piece_o.dst = cur_q.dst;
  assign piece_o.num_bytes = piece_len;

  assign valid_o = busy_q;
  assign ready_o = !busy_q;
  assign busy_o = busy_q;

endmodule

/* hw/dma_group_distributor.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Splits a row piece into one chunk per group window and
// offers each chunk on its group port until it is taken
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "dma_defines.svh"

module dma_group_distributor (
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,
  input  dma_pkg::dma_req_t                       piece_i,
  input  logic                                    valid_i,
  output logic                                    ready_o,
  output dma_pkg::dma_req_t [`DMA_NUM_GROUPS-1:0] group_req_o,
  output logic              [`DMA_NUM_GROUPS-1:0] group_valid_o,
  input  logic              [`DMA_NUM_GROUPS-1:0] group_ready_i,
  output logic                                    busy_o
);
  import dma_pkg::*;

  localparam int unsigned NumGroups = `DMA_NUM_GROUPS;

  // Chunk bounds inside a group, up to and including GroupBytes
  typedef logic [OffsetWidth:0] span_t;

  logic     [NumGroups-1:0] pending_q;
  logic     [NumGroups-1:0] hit_d;
  dma_req_t [NumGroups-1:0] chunk_q;
  dma_req_t [NumGroups-1:0] chunk_d;
  tcdm_addr_u               first_rel;
  tcdm_addr_u               last_rel;
  logic                     accept;

  // First and last byte of the piece, relative to the scratchpad
  assign first_rel.raw = piece_i.dst.raw - TcdmBase;
  assign last_rel.raw = first_rel.raw + addr_t'(piece_i.num_bytes) - addr_t'(1);

  always_comb begin
    logic [GroupIdxWidth-1:0]             gi;
    logic [OffsetWidth-1:0]               lo_off;
    span_t                                hi_off;
    logic [GroupIdxWidth+OffsetWidth-1:0] skip;
    for (int g = 0; g < NumGroups; g++) begin
      gi = GroupIdxWidth'(g);
      hit_d[g] = (piece_i.num_bytes != '0) &&
                 (gi >= first_rel.fields.group) &&
                 (gi <= last_rel.fields.group);
      // Inner groups take their whole window
      lo_off = (gi == first_rel.fields.group) ? first_rel.fields.offset : '0;
      hi_off = (gi == last_rel.fields.group) ?
               {1'b0, last_rel.fields.offset} + span_t'(1) : span_t'(GroupBytes);
      skip = {gi, lo_off} - {first_rel.fields.group, first_rel.fields.offset};
      chunk_d[g].src = piece_i.src + addr_t'(skip);
      chunk_d[g].dst.raw = piece_i.dst.raw + addr_t'(skip);
      chunk_d[g].num_bytes = len_t'(hi_off - {1'b0, lo_off});
    end
  end

  assign accept = valid_i && ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= '0;
    end else if (accept) begin
      pending_q <= hit_d;
    end else begin
      pending_q <= pending_q & ~group_ready_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      chunk_q <= chunk_d;
    end
  end

  assign group_req_o = chunk_q;
  assign group_valid_o = pending_q;
  assign busy_o = |pending_q;
  assign ready_o = ~|pending_q;

endmodule

/* hw/dma_cluster_midend.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMA request path of the cluster: spill, row split, group
// distribution, plus the registered idle status
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "dma_defines.svh"

module dma_cluster_midend (
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,
  input  dma_pkg::dma_req_t                       dma_req_i,
  input  logic                                    dma_req_valid_i,
  output logic                                    dma_req_ready_o,
  output dma_pkg::dma_req_t [`DMA_NUM_GROUPS-1:0] dma_group_req_o,
  output logic              [`DMA_NUM_GROUPS-1:0] dma_group_valid_o,
  input  logic              [`DMA_NUM_GROUPS-1:0] dma_group_ready_i,
  input  logic              [`DMA_NUM_GROUPS-1:0] group_idle_i,
  output logic                                    dma_idle_o
);
  import dma_pkg::*;

  dma_req_t req_cut;
  logic     req_cut_valid;
  logic     req_cut_ready;
  dma_req_t req_piece;
  logic     req_piece_valid;
  logic     req_piece_ready;
  logic     split_busy;
  logic     dist_busy;
  logic     idle_q;

  dma_req_spill i_req_spill (
    .clk_i   (clk_i          ),
    .arst_n_i(arst_n_i       ),
    .data_i  (dma_req_i      ),
    .valid_i (dma_req_valid_i),
    .ready_o (dma_req_ready_o),
    .data_o  (req_cut        ),
    .valid_o (req_cut_valid  ),
    .ready_i (req_cut_ready  )
  );

  dma_row_splitter i_row_splitter (
    .clk_i   (clk_i          ),
    .arst_n_i(arst_n_i       ),
    .req_i   (req_cut        ),
    .valid_i (req_cut_valid  ),
    .ready_o (req_cut_ready  ),
    .piece_o (req_piece      ),
    .valid_o (req_piece_valid),
    .ready_i (req_piece_ready),
    .busy_o  (split_busy     )
  );

  dma_group_distributor i_group_distributor (
    .clk_i        (clk_i            ),
    .arst_n_i     (arst_n_i         ),
    .piece_i      (req_piece        ),
    .valid_i      (req_piece_valid  ),
    .ready_o      (req_piece_ready  ),
    .group_req_o  (dma_group_req_o  ),
    .group_valid_o(dma_group_valid_o),
    .group_ready_i(dma_group_ready_i),
    .busy_o       (dist_busy        )
  );

  // Spill is empty exactly when it offers nothing
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      idle_q <= 1'b1;
    end else begin
      idle_q <= !req_cut_valid && !split_busy && !dist_busy && (&group_idle_i);
    end
  end

  assign dma_idle_o = idle_q;

endmodule

/* dv/tb_dma_midend.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the DMA request path. A reference
// model predicts each group's chunks and a monitor checks them
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "dma_defines.svh"

module tb_dma_midend;
  import dma_pkg::*;

  localparam int NumGroups = `DMA_NUM_GROUPS;
  localparam int unsigned TcdmSize = `DMA_TCDM_SIZE;
  localparam int Timeout = 3000;

  logic                     clk;
  logic                     arst_n;
  dma_req_t                 dma_req;
  logic                     dma_req_valid;
  logic                     dma_req_ready;
  dma_req_t [NumGroups-1:0] group_req;
  logic     [NumGroups-1:0] group_valid;
  logic     [NumGroups-1:0] group_ready;
  logic     [NumGroups-1:0] group_idle;
  logic                     dma_idle;
  logic                     ready_random;
  logic     [NumGroups-1:0] ready_fixed;
  logic                     saw_stall;
  logic     [31:0]          lfsr;
  int                       errors;
  int                       checks;
  dma_req_t                 exp_q[NumGroups][$];

  dma_cluster_midend dut (
    .clk_i            (clk          ),
    .arst_n_i         (arst_n       ),
    .dma_req_i        (dma_req      ),
    .dma_req_valid_i  (dma_req_valid),
    .dma_req_ready_o  (dma_req_ready),
    .dma_group_req_o  (group_req    ),
    .dma_group_valid_o(group_valid  ),
    .dma_group_ready_i(group_ready  ),
    .group_idle_i     (group_idle   ),
    .dma_idle_o       (dma_idle     )
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic rand_bit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_word(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], rand_bit()};
    end
    return val;
  endfunction

  task automatic check_value(input string name, input logic [79:0] expected,
                             input logic [79:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  // Cuts row pieces first and then one chunk per group window in each piece
  task automatic model_req(input dma_req_t req);
    int unsigned start;
    int unsigned pos;
    int unsigned stop;
    int unsigned piece_end;
    int unsigned chunk_end;
    int          g;
    dma_req_t    chunk;
    start = req.dst.raw - TcdmBase;
    pos = start;
    stop = start + 32'(req.num_bytes);
    while (pos < stop) begin
      piece_end = (pos / RowBytes + 1) * RowBytes;
      if (piece_end > stop) begin
        piece_end = stop;
      end
      while (pos < piece_end) begin
        chunk_end = (pos / GroupBytes + 1) * GroupBytes;
        if (chunk_end > piece_end) begin
          chunk_end = piece_end;
        end
        g = (pos / GroupBytes) % NumGroups;
        chunk.src = req.src + addr_t'(pos - start);
        chunk.dst.raw = TcdmBase + addr_t'(pos);
        chunk.num_bytes = len_t'(chunk_end - pos);
        exp_q[g].push_back(chunk);
        pos = chunk_end;
      end
    end
  endtask

  task automatic drive_readies();
    forever begin
      @(posedge clk);
      #1;
      for (int g = 0; g < NumGroups; g++) begin
        if (ready_random) begin
          group_ready[g] = rand_bit() & rand_bit();
        end else begin
          group_ready[g] = ready_fixed[g];
        end
      end
    end
  endtask

  // Handshakes are sampled mid-cycle and transfer on the next edge
  task automatic watch_groups();
    forever begin
      @(negedge clk);
      if (arst_n) begin
        if (!dma_req_ready) begin
          saw_stall = 1'b1;
        end
        for (int g = 0; g < NumGroups; g++) begin
          if (group_valid[g] && group_ready[g]) begin
            if (exp_q[g].size() == 0) begin
              errors++;
              $display("ERROR at %0t: group %0d got a chunk no request predicts", $time, g);
            end else begin
              check_value($sformatf("dma_group_req_o[%0d]", g), exp_q[g].pop_front(),
                          group_req[g]);
            end
          end
        end
      end
    end
  endtask

  task automatic send_req(input dma_req_t req);
    int waited;
    waited = 0;
    dma_req = req;
    dma_req_valid = 1'b1;
    @(negedge clk);
    while (!dma_req_ready && waited < Timeout) begin
      waited++;
      @(negedge clk);
    end
    if (dma_req_ready) begin
      model_req(req);
    end else begin
      errors++;
      $display("TIMEOUT at %0t: request was not accepted in %0d cycles", $time, Timeout);
    end
    @(posedge clk);
    #1;
    dma_req_valid = 1'b0;
  endtask

  function automatic int outstanding();
    int n;
    n = 0;
    for (int g = 0; g < NumGroups; g++) begin
      n += exp_q[g].size();
    end
    return n;
  endfunction

  // Waits until every expected chunk is out and the path reports idle
  task automatic wait_settled(input string name);
    int waited;
    waited = 0;
    @(negedge clk);
    while ((outstanding() != 0 || group_valid != '0 || !dma_idle) && waited < Timeout) begin
      waited++;
      @(negedge clk);
    end
    if (waited >= Timeout) begin
      errors++;
      $display("TIMEOUT in %s: %0d chunks left or never idle", name, outstanding());
    end
    @(posedge clk);
    #1;
  endtask

  task automatic set_ready(input logic random_en, input logic [NumGroups-1:0] fixed);
    @(negedge clk);
    ready_random = random_en;
    ready_fixed = fixed;
    @(posedge clk);
    #1;
  endtask

  task automatic sample_idle(input logic expected);
    @(negedge clk);
    check_value("dma_idle_o", 80'(expected), 80'(dma_idle));
    @(posedge clk);
    #1;
  endtask

  task automatic random_req(output dma_req_t req, input int unsigned min_len);
    int unsigned dst;
    int unsigned len;
    len = min_len + rand_word(9);
    dst = rand_word(12);
    if (dst + len > TcdmSize) begin
      dst = TcdmSize - len;
    end
    req.src = rand_word(32);
    req.dst.raw = TcdmBase + addr_t'(dst);
    req.num_bytes = len_t'(len);
  endtask

  task automatic make_req(output dma_req_t req, input addr_t src, input addr_t dst,
                          input int unsigned len);
    req.src = src;
    req.dst.raw = TcdmBase + dst;
    req.num_bytes = len_t'(len);
  endtask

  task automatic report_test(input string name, input int start);
    $display("test %s: %0d errors", name, errors - start);
  endtask

  task automatic test_reset();
    int start;
    start = errors;
    @(negedge clk);
    check_value("dma_req_ready_o", 80'(1), 80'(dma_req_ready));
    check_value("dma_group_valid_o", 80'(0), 80'(group_valid));
    check_value("dma_idle_o", 80'(1), 80'(dma_idle));
    @(posedge clk);
    #1;
    report_test("reset", start);
  endtask

  task automatic test_one_group();
    int       start;
    dma_req_t req;
    start = errors;
    // Inside the window of group 1 in row 1
    make_req(req, 32'h8000_1000, 32'h148, 40);
    send_req(req);
    wait_settled("one group");
    report_test("one group", start);
  endtask

  task automatic test_multi_group();
    int       start;
    dma_req_t req;
    start = errors;
    make_req(req, 32'h0001_0000, 32'h250, 80);
    send_req(req);
    wait_settled("multi group");
    make_req(req, 32'h0002_0004, 32'h5B0, 64);
    send_req(req);
    wait_settled("multi group");
    report_test("multi group", start);
  endtask

  task automatic test_random_rows();
    int       start;
    dma_req_t req;
    start = errors;
    for (int i = 0; i < 6; i++) begin
      random_req(req, 512);
      send_req(req);
      wait_settled("random rows");
    end
    req.num_bytes = '0;
    send_req(req);
    wait_settled("zero length");
    report_test("random rows", start);
  endtask

  task automatic test_backpressure();
    int       start;
    dma_req_t reqs[8];
    start = errors;
    for (int i = 0; i < 8; i++) begin
      random_req(reqs[i], 1);
    end
    saw_stall = 1'b0;
    set_ready(1'b1, '1);
    for (int i = 0; i < 8; i++) begin
      send_req(reqs[i]);
    end
    set_ready(1'b0, '1);
    wait_settled("backpressure");
    if (!saw_stall) begin
      errors++;
      $display("ERROR: dma_req_ready_o never fell while the groups stalled");
    end
    report_test("backpressure", start);
  endtask

  task automatic test_idle();
    int       start;
    dma_req_t req;
    start = errors;
    set_ready(1'b0, '0);
    make_req(req, 32'h0004_0000, 32'h3F0, 40);
    send_req(req);
    // Idle flag sees the filled spill one cycle after acceptance
    @(posedge clk);
    #1;
    repeat (4) sample_idle(1'b0);
    set_ready(1'b0, '1);
    wait_settled("idle drain");
    group_idle = 4'b1101;
    repeat (2) @(posedge clk);
    #1;
    sample_idle(1'b0);
    group_idle = '1;
    wait_settled("idle groups");
    report_test("idle", start);
  endtask

  initial begin
    lfsr = 32'd69234;
    errors = 0;
    checks = 0;
    saw_stall = 1'b0;
    arst_n = 1'b0;
    dma_req = '0;
    dma_req_valid = 1'b0;
    group_idle = '1;
    group_ready = '1;
    ready_random = 1'b0;
    ready_fixed = '1;
    fork
      drive_readies();
      watch_groups();
    join_none
    repeat (4) @(posedge clk);
    #1;
    arst_n = 1'b1;
    test_reset();
    test_one_group();
    test_multi_group();
    test_random_rows();
    test_backpressure();
    test_idle();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+hw
hw/dma_pkg.sv
hw/dma_req_spill.sv
hw/dma_row_splitter.sv
hw/dma_group_distributor.sv
hw/dma_cluster_midend.sv
dv/tb_dma_midend.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_dma_midend
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
